// ==== build.f ====
hw/chol_num_pkg.sv
hw/chol_ctrl_pkg.sv
hw/chol_ifs.sv
hw/chol_isqrt.sv
hw/chol_divider.sv
hw/chol_traversal.sv
hw/chol_factor_store.sv
hw/chol_element_engine.sv
hw/chol_top.sv
bench/chol_checker.sv
bench/chol_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile the Cholesky testbench with Verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing -Wno-fatal -f build.f --top-module chol_tb -Mdir "$build_dir"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/Vchol_tb" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Simulation failed" "$log_file"; then
    exit 1
fi
exit 0

// ==== bench/chol_tb.sv ====
// testbench: clock, reset, factor table, random factors, watchdog, closing report
`timescale 1ns/100ps
`default_nettype none

module chol_tb;
    import chol_num_pkg::*;

    localparam int SIZE        = 4;
    localparam int CELLS       = SIZE * SIZE;
    localparam int ELEMS       = SIZE * (SIZE + 1) / 2;
    localparam int NUM_TAB     = 5;
    localparam int NUM_RAND    = 4;
    localparam int NUM_CASES   = NUM_TAB + NUM_RAND;
    localparam int WATCHDOG_NS = NUM_CASES * ELEMS * (SIZE + DIV_STEPS + 4) * 10 * 2;

    // integer factors L, row-major, upper triangle zero
    localparam int L_TAB [NUM_TAB][CELLS] = '{
        '{  1,   0,   0,   0,    0,   1,   0,   0,    0,   0,   1,   0,    0,   0,   0,   1},
        '{  1,   0,   0,   0,    0,   2,   0,   0,    0,   0,   3,   0,    0,   0,   0,   4},
        '{  2,   0,   0,   0,    1,   3,   0,   0,   -4,   2,   5,   0,    3,  -1,   2,   1},
        '{ 15,   0,   0,   0,  -15,   7,   0,   0,    9, -12,  11,   0,   -8,  14, -13,   6},
        '{  1,   0,   0,   0,   -3,   2,   0,   0,    5,  -7,   4,   0,  -15,  15,  -9,  13}
    };
    localparam bit RESTART_TAB [NUM_TAB] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0};  // start while busy

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    start;
    logic [CELLS*WORD_W-1:0] matrix;
    logic [CELLS*WORD_W-1:0] factor;
    logic                    done;
    logic [CELLS*WORD_W-1:0] expected;
    logic                    idle_chk;
    int                      value_errs;
    int                      proto_errs;
    int                      runs;
    int                      tb_errs;
    integer                  seed;
    int                      l_cur [CELLS];

    always #5 clk = ~clk;

    chol_top #(.SIZE(SIZE)) dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .start_i  (start),
        .matrix_i (matrix),
        .factor_o (factor),
        .done_o   (done)
    );

    chol_checker #(.SIZE(SIZE)) u_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start),
        .done_i       (done),
        .factor_i     (factor),
        .expect_i     (expected),
        .idle_chk_i   (idle_chk),
        .value_errs_o (value_errs),
        .proto_errs_o (proto_errs),
        .runs_o       (runs)
    );

    // A = L*L^T in integers, then both A and L into Q16.16
    task automatic build_case();
        int acc;
        for (int r = 0; r < SIZE; r++) begin
            for (int c = 0; c < SIZE; c++) begin
                acc = 0;
                for (int k = 0; k < SIZE; k++) begin
                    acc += l_cur[r*SIZE+k] * l_cur[c*SIZE+k];
                end
                matrix[(r*SIZE+c)*WORD_W +: WORD_W]   = acc * (1 << FRAC_W);
                expected[(r*SIZE+c)*WORD_W +: WORD_W] = l_cur[r*SIZE+c] * (1 << FRAC_W);
            end
        end
    endtask

    task automatic random_factor();
        int v;
        for (int r = 0; r < SIZE; r++) begin
            for (int c = 0; c < SIZE; c++) begin
                if (c > r) begin
                    l_cur[r*SIZE+c] = 0;
                end else if (c == r) begin
                    v = $random(seed) % 15;
                    if (v < 0) v = -v;
                    l_cur[r*SIZE+c] = v + 1;          // diagonal 1 to 15
                end else begin
                    l_cur[r*SIZE+c] = $random(seed) % 16;
                end
            end
        end
    endtask

    task automatic run_case(input bit restart);
        @(posedge clk);
        #1;
        build_case();
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        if (restart) begin
            repeat (20) @(posedge clk);
            #1;
            matrix = ~matrix;                         // must not reach the result
            start  = 1'b1;
            @(posedge clk);
            #1;
            start = 1'b0;
        end
        while (!done) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        seed     = 88;
        rst_n    = 1'b0;
        start    = 1'b0;
        matrix   = '0;
        expected = '0;
        idle_chk = 1'b0;
        tb_errs  = 0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        idle_chk = 1'b1;
        @(posedge clk);
        #1;
        idle_chk = 1'b0;
        for (int t = 0; t < NUM_TAB; t++) begin
            for (int n = 0; n < CELLS; n++) begin
                l_cur[n] = L_TAB[t][n];
            end
            run_case(RESTART_TAB[t]);
        end
        for (int t = 0; t < NUM_RAND; t++) begin
            random_factor();
            run_case(1'b0);
        end
        repeat (3) @(posedge clk);
        if (runs != NUM_CASES) begin
            tb_errs++;
            $display("only %0d of %0d runs raised done_o", runs, NUM_CASES);
        end
        $display("errors: %0d value, %0d protocol, %0d runs checked",
                 value_errs, proto_errs + tb_errs, runs);
        if (value_errs == 0 && proto_errs + tb_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns without finishing all runs", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/chol_checker.sv ====
// result checker: factor compare on done, start and done protocol, error counters
`timescale 1ns/100ps
`default_nettype none

module chol_checker #(
    parameter int SIZE = 4
) (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      start_i,
    input  logic                                      done_i,
    input  logic [SIZE*SIZE*chol_num_pkg::WORD_W-1:0] factor_i,
    input  logic [SIZE*SIZE*chol_num_pkg::WORD_W-1:0] expect_i,
    input  logic                                      idle_chk_i,  // done low, factor zero
    output int                                        value_errs_o,
    output int                                        proto_errs_o,
    output int                                        runs_o
);
    import chol_num_pkg::*;

    localparam int CELLS = SIZE * SIZE;

    int                    value_errs = 0;
    int                    proto_errs = 0;
    int                    runs       = 0;
    logic                  done_q;
    logic                  accept_q;          // start seen while finished
    logic [CELLS*WORD_W-1:0] held_q;          // factor at the previous sample

    assign value_errs_o = value_errs;
    assign proto_errs_o = proto_errs;
    assign runs_o       = runs;

    task automatic compare_factor();
        logic [WORD_W-1:0] exp_w;
        logic [WORD_W-1:0] act_w;
        for (int n = 0; n < CELLS; n++) begin
            exp_w = expect_i[n*WORD_W +: WORD_W];
            act_w = factor_i[n*WORD_W +: WORD_W];
            if (act_w !== exp_w) begin
                value_errs++;
                $display("ERR factor_o[%0d][%0d] expected %h actual %h at %0t",
                         n / SIZE, n % SIZE, exp_w, act_w, $time);
            end
        end
    endtask

    // outputs are settled half a cycle after the rising edge
    always @(negedge clk) begin
        if (!rst_n) begin
            done_q   <= 1'b0;
            accept_q <= 1'b0;
            held_q   <= '0;
        end else begin
            if (accept_q && done_i) begin
                proto_errs++;
                $display("done_o stayed high after an accepted start at %0t", $time);
            end
            if (accept_q && factor_i !== '0) begin
                proto_errs++;
                $display("factor_o was not cleared by an accepted start at %0t", $time);
            end
            if (done_i && !done_q) begin
                runs++;
                compare_factor();
            end else if (done_i && done_q && factor_i !== held_q) begin
                proto_errs++;
                $display("factor_o changed while done_o was high at %0t", $time);
            end
            if (idle_chk_i && (done_i !== 1'b0 || factor_i !== '0)) begin
                proto_errs++;
                $display("done_o or factor_o not idle after reset at %0t", $time);
            end
            done_q   <= done_i;
            held_q   <= factor_i;
            accept_q <= start_i && done_i;    // traversal is idle while done is high
        end
    end

endmodule

`default_nettype wire

// ==== hw/chol_top.sv ====
// Cholesky factor top level: traversal, factor store, element engine
`timescale 1ns/100ps
`default_nettype none

module chol_top #(
    parameter int SIZE = 4
) (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      start_i,
    input  logic [SIZE*SIZE*chol_num_pkg::WORD_W-1:0] matrix_i,  // element (r,c) at word r*SIZE+c
    output logic [SIZE*SIZE*chol_num_pkg::WORD_W-1:0] factor_o,
    output logic                                      done_o
);

    logic load;
    logic finish;

    chol_job_if   job_bus ();
    chol_store_if store_bus ();

    chol_traversal #(.SIZE(SIZE)) u_traversal (
        .clk      (clk),
        .rst_n    (rst_n),
        .start_i  (start_i),
        .load_o   (load),
        .finish_o (finish),
        .job      (job_bus.traversal)
    );

    chol_factor_store #(.SIZE(SIZE)) u_store (
        .clk      (clk),
        .rst_n    (rst_n),
        .load_i   (load),
        .finish_i (finish),
        .matrix_i (matrix_i),
        .factor_o (factor_o),
        .done_o   (done_o),
        .st       (store_bus.store)
    );

    chol_element_engine u_engine (
        .clk   (clk),
        .rst_n (rst_n),
        .job   (job_bus.engine),
        .st    (store_bus.engine)
    );

endmodule

`default_nettype wire

// ==== hw/chol_element_engine.sv ====
// element engine: multiply-accumulate, subtraction, dispatch to root or divide
`timescale 1ns/100ps
`default_nettype none

module chol_element_engine (
    input  logic        clk,
    input  logic        rst_n,
    chol_job_if.engine  job,
    chol_store_if.engine st
);
    import chol_num_pkg::*;
    import chol_ctrl_pkg::*;

    logic [ST_W-1:0]          state_q;
    logic [IDX_W-1:0]         i_q;
    logic [IDX_W-1:0]         j_q;
    logic [IDX_W-1:0]         k_q;
    logic                     diag_q;
    logic [WORD_W-1:0]        acc_q;        // running sum of l_ik*l_jk
    logic signed [PROD_W-1:0] prod;
    logic [WORD_W-1:0]        diff;
    logic                     sqrt_start;
    logic                     div_start;
    logic                     sqrt_valid;
    logic                     div_valid;
    logic [WORD_W-1:0]        root;
    logic [WORD_W-1:0]        quot;

    assign prod = $signed(st.l_ik) * $signed(st.l_jk);
    assign diff = st.a_ij - acc_q;          // k has reached j here, so l_jk is l_jj

    assign st.idx_i   = i_q;
    assign st.idx_j   = j_q;
    assign st.idx_k   = k_q;
    assign st.wr_en   = (state_q == ST_WRITE);
    assign st.wr_data = diag_q ? root : quot;
    assign job.done   = (state_q == ST_WRITE);

    assign sqrt_start = (state_q == ST_SUB) & diag_q;
    assign div_start  = (state_q == ST_SUB) & ~diag_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (job.start) state_q <= (job.col == '0) ? ST_SUB : ST_MAC;
                end
                ST_MAC: begin
                    if (k_q == j_q - 1'b1) state_q <= ST_SUB;
                end
                ST_SUB:  state_q <= ST_WAIT;
                ST_WAIT: begin
                    if (sqrt_valid || div_valid) state_q <= ST_WRITE;
                end
                ST_WRITE: state_q <= ST_IDLE;
                default:  state_q <= ST_IDLE;
            endcase
        end
    end

    // job fields and accumulator
    always_ff @(posedge clk) begin
        case (state_q)
            ST_IDLE: begin
                if (job.start) begin
                    i_q    <= job.row;
                    j_q    <= job.col;
                    diag_q <= job.diag;
                    k_q    <= '0;
                    acc_q  <= '0;
                end
            end
            ST_MAC: begin
                acc_q <= acc_q + prod[FRAC_W +: WORD_W];    // truncated product
                k_q   <= k_q + 1'b1;
            end
            default: ;
        endcase
    end

    chol_isqrt u_isqrt (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (sqrt_start),
        .radicand_i (diff),
        .root_o     (root),
        .valid_o    (sqrt_valid)
    );

    chol_divider u_divider (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (div_start),
        .dividend_i (diff),
        .divisor_i  (st.l_jk),
        .quotient_o (quot),
        .valid_o    (div_valid)
    );

endmodule

`default_nettype wire

// ==== hw/chol_factor_store.sv ====
// snapshot of A, register grid for L, operand reads, result writes and done flag
`timescale 1ns/100ps
`default_nettype none

module chol_factor_store #(
    parameter int SIZE = 4
) (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        load_i,
    input  logic                                        finish_i,
    input  logic [SIZE*SIZE*chol_num_pkg::WORD_W-1:0]   matrix_i,
    output logic [SIZE*SIZE*chol_num_pkg::WORD_W-1:0]   factor_o,
    output logic                                        done_o,
    chol_store_if.store                                 st
);
    import chol_num_pkg::*;

    localparam int CELLS = SIZE * SIZE;

    logic [CELLS*WORD_W-1:0] a_q;            // captured A, row-major
    logic [WORD_W-1:0]       l_q [CELLS];
    int                      ij_addr;
    int                      ik_addr;
    int                      jk_addr;

    assign ij_addr = st.idx_i * SIZE + st.idx_j;
    assign ik_addr = st.idx_i * SIZE + st.idx_k;
    assign jk_addr = st.idx_j * SIZE + st.idx_k;

    assign st.a_ij = a_q[ij_addr*WORD_W +: WORD_W];
    assign st.l_ik = l_q[ik_addr];
    assign st.l_jk = l_q[jk_addr];

    always_comb begin
        for (int n = 0; n < CELLS; n++) begin
            factor_o[n*WORD_W +: WORD_W] = l_q[n];
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) a_q <= matrix_i;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int n = 0; n < CELLS; n++) l_q[n] <= '0;
        end else if (load_i) begin
            for (int n = 0; n < CELLS; n++) l_q[n] <= '0;   // upper triangle stays zero
        end else if (st.wr_en) begin
            l_q[ij_addr] <= st.wr_data;
        end
    end

    // load wins over a finish in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_o <= 1'b0;
        end else if (load_i) begin
            done_o <= 1'b0;
        end else if (finish_i) begin
            done_o <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hw/chol_traversal.sv ====
// lower-triangle walker issuing one element job at a time
`timescale 1ns/100ps
`default_nettype none

module chol_traversal #(
    parameter int SIZE = 4
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start_i,
    output logic        load_o,
    output logic        finish_o,
    chol_job_if.traversal job
);
    import chol_ctrl_pkg::*;

    localparam logic [IDX_W-1:0] LAST = IDX_W'(SIZE - 1);

    logic             busy_q;
    logic [IDX_W-1:0] row_q;
    logic [IDX_W-1:0] col_q;
    logic             start_q;

    assign load_o    = start_i & ~busy_q;   // starts while busy are dropped
    assign job.start = start_q;
    assign job.row   = row_q;
    assign job.col   = col_q;
    assign job.diag  = (row_q == col_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q   <= 1'b0;
            row_q    <= '0;
            col_q    <= '0;
            start_q  <= 1'b0;
            finish_o <= 1'b0;
        end else begin
            start_q  <= 1'b0;
            finish_o <= 1'b0;
            if (load_o) begin
                busy_q  <= 1'b1;
                row_q   <= '0;
                col_q   <= '0;
                start_q <= 1'b1;                // first job once A is captured
            end else if (busy_q && job.done) begin
                if (col_q == row_q) begin
                    if (row_q == LAST) begin
                        busy_q   <= 1'b0;
                        finish_o <= 1'b1;
                    end else begin
                        row_q   <= row_q + 1'b1;
                        col_q   <= '0;
                        start_q <= 1'b1;
                    end
                end else begin
                    col_q   <= col_q + 1'b1;    // stay in the row
                    start_q <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/chol_divider.sv ====
// iterative signed Q16.16 divider, restoring division on magnitudes
`timescale 1ns/100ps
`default_nettype none

module chol_divider (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            start_i,
    input  logic [chol_num_pkg::WORD_W-1:0] dividend_i,
    input  logic [chol_num_pkg::WORD_W-1:0] divisor_i,
    output logic [chol_num_pkg::WORD_W-1:0] quotient_o,
    output logic                            valid_o
);
    import chol_num_pkg::*;

    localparam int CNT_W = $clog2(DIV_STEPS + 1);

    logic                     busy_q;
    logic [CNT_W-1:0]         cnt_q;
    logic                     neg_q;
    logic [WORD_W-1:0]        dvs_q;
    logic [WORD_W-1:0]        rem_q;
    logic [DIV_STEPS-1:0]     quo_q;    // numerator bits shift out, quotient bits shift in
    logic [WORD_W-1:0]        mag_a;
    logic [WORD_W-1:0]        mag_b;
    logic [WORD_W+FRAC_W-1:0] num;
    logic [WORD_W:0]          trial;
    logic [WORD_W:0]          diff;
    logic                     ge;
    logic [WORD_W-1:0]        q_mag;

    assign mag_a = dividend_i[WORD_W-1] ? (~dividend_i + 1'b1) : dividend_i;
    assign mag_b = divisor_i[WORD_W-1]  ? (~divisor_i + 1'b1)  : divisor_i;
    assign num   = {mag_a, {FRAC_W{1'b0}}};

    assign trial = {rem_q, quo_q[DIV_STEPS-1]};
    assign diff  = trial - {1'b0, dvs_q};
    assign ge    = (trial >= {1'b0, dvs_q});

    assign q_mag      = WORD_W'(quo_q);
    assign quotient_o = neg_q ? (~q_mag + 1'b1) : q_mag;   // truncated toward zero

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q  <= 1'b0;
            cnt_q   <= '0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= 1'b0;
            if (start_i) begin
                busy_q <= 1'b1;
                cnt_q  <= CNT_W'(DIV_STEPS);
            end else if (busy_q) begin
                cnt_q <= cnt_q - 1'b1;
                if (cnt_q == CNT_W'(1)) begin
                    busy_q  <= 1'b0;
                    valid_o <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            neg_q <= dividend_i[WORD_W-1] ^ divisor_i[WORD_W-1];
            dvs_q <= mag_b;
            rem_q <= WORD_W'(num >> DIV_STEPS);     // upper numerator bits
            quo_q <= num[DIV_STEPS-1:0];
        end else if (busy_q) begin
            rem_q <= ge ? diff[WORD_W-1:0] : trial[WORD_W-1:0];
            quo_q <= {quo_q[DIV_STEPS-2:0], ge};
        end
    end

endmodule

`default_nettype wire

// ==== hw/chol_isqrt.sv ====
// iterative restoring square root of a Q16.16 value
`timescale 1ns/100ps
`default_nettype none

module chol_isqrt (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            start_i,
    input  logic [chol_num_pkg::WORD_W-1:0] radicand_i,
    output logic [chol_num_pkg::WORD_W-1:0] root_o,
    output logic                            valid_o
);
    import chol_num_pkg::*;

    localparam int RAD_W = WORD_W + FRAC_W;
    localparam int REM_W = SQRT_STEPS + 2;
    localparam int CNT_W = $clog2(SQRT_STEPS + 1);

    logic                  busy_q;
    logic [CNT_W-1:0]      cnt_q;
    logic [RAD_W-1:0]      rad_q;       // radicand, top two bits consumed per step
    logic [REM_W-1:0]      rem_q;
    logic [SQRT_STEPS-1:0] root_q;
    logic [REM_W+1:0]      trial;
    logic [REM_W+1:0]      test;
    logic [REM_W+1:0]      rem_diff;
    logic                  ge;

    assign trial    = {rem_q, rad_q[RAD_W-1 -: 2]};
    assign test     = {2'b00, root_q, 2'b01};
    assign rem_diff = trial - test;
    assign ge       = (trial >= test);
    assign root_o   = {{(WORD_W-SQRT_STEPS){1'b0}}, root_q};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q  <= 1'b0;
            cnt_q   <= '0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= 1'b0;
            if (start_i) begin
                busy_q <= 1'b1;
                cnt_q  <= CNT_W'(SQRT_STEPS);
            end else if (busy_q) begin
                cnt_q <= cnt_q - 1'b1;
                if (cnt_q == CNT_W'(1)) begin
                    busy_q  <= 1'b0;
                    valid_o <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            rad_q  <= {radicand_i, {FRAC_W{1'b0}}};    // keeps the root in Q16.16
            rem_q  <= '0;
            root_q <= '0;
        end else if (busy_q) begin
            rad_q  <= rad_q << 2;
            rem_q  <= ge ? rem_diff[REM_W-1:0] : trial[REM_W-1:0];
            root_q <= {root_q[SQRT_STEPS-2:0], ge};
        end
    end

endmodule

`default_nettype wire

// ==== hw/chol_ifs.sv ====
// job interface (traversal to engine) and store-access interface (engine to store)
`timescale 1ns/100ps
`default_nettype none

interface chol_job_if;
    import chol_ctrl_pkg::*;

    logic             start;    // one-cycle pulse per element
    logic [IDX_W-1:0] row;
    logic [IDX_W-1:0] col;
    logic             diag;     // row equals col
    logic             done;     // pulse once the element is written

    modport traversal (
        output start, row, col, diag,
        input  done
    );

    modport engine (
        input  start, row, col, diag,
        output done
    );

endinterface

interface chol_store_if;
    import chol_num_pkg::*;
    import chol_ctrl_pkg::*;

    logic [IDX_W-1:0]  idx_i;
    logic [IDX_W-1:0]  idx_j;
    logic [IDX_W-1:0]  idx_k;
    logic              wr_en;      // writes L at (idx_i, idx_j)
    logic [WORD_W-1:0] wr_data;
    logic [WORD_W-1:0] a_ij;
    logic [WORD_W-1:0] l_ik;
    logic [WORD_W-1:0] l_jk;       // l_jj when idx_k equals idx_j

    modport engine (
        output idx_i, idx_j, idx_k, wr_en, wr_data,
        input  a_ij, l_ik, l_jk
    );

    modport store (
        input  idx_i, idx_j, idx_k, wr_en, wr_data,
        output a_ij, l_ik, l_jk
    );

endinterface

`default_nettype wire

// ==== hw/chol_ctrl_pkg.sv ====
// index width and element engine sequencing codes
`default_nettype none

package chol_ctrl_pkg;

    localparam int MAX_SIZE = 16;
    localparam int IDX_W    = $clog2(MAX_SIZE);    // row, column and k indices

    // element engine states
    localparam int              ST_W     = 3;
    localparam logic [ST_W-1:0] ST_IDLE  = 3'd0;
    localparam logic [ST_W-1:0] ST_MAC   = 3'd1;
    localparam logic [ST_W-1:0] ST_SUB   = 3'd2;
    localparam logic [ST_W-1:0] ST_WAIT  = 3'd3;
    localparam logic [ST_W-1:0] ST_WRITE = 3'd4;

endpackage

`default_nettype wire

// ==== hw/chol_num_pkg.sv ====
// fixed-point number format constants for the Q16.16 datapath
`default_nettype none

package chol_num_pkg;

    localparam int WORD_W = 32;            // one matrix or factor element
    localparam int FRAC_W = 16;            // fraction bits of Q16.16
    localparam int PROD_W = 2 * WORD_W;    // full signed product

    // radicand is widened by FRAC_W bits, two bits consumed per step
    localparam int SQRT_STEPS = (WORD_W + FRAC_W) / 2;

    localparam int DIV_STEPS = 32;         // quotient bits per divide

endpackage

`default_nettype wire
